// File: hdl/dispatch_pkg.sv
package dispatch_pkg;

   // Datapath widths
   localparam int word_w     = 32;
   localparam int reg_addr_w = 5;
   localparam int num_regs   = 32;
   localparam int tag_w      = 6;
   localparam int num_tags   = 64;

   // MIPS instruction field widths
   localparam int opcode_w = 6;
   localparam int funct_w  = 6;
   localparam int imm_w    = 16;
   localparam int jaddr_w  = 26;

   localparam logic [opcode_w-1:0] opcode_rtype = 6'h00;
   localparam logic [opcode_w-1:0] opcode_j     = 6'h02;
   localparam logic [opcode_w-1:0] opcode_beq   = 6'h04;
   localparam logic [opcode_w-1:0] opcode_bne   = 6'h05;
   localparam logic [opcode_w-1:0] opcode_lw    = 6'h23;
   localparam logic [opcode_w-1:0] opcode_sw    = 6'h2B;

   localparam logic [funct_w-1:0] funct_mult  = 6'h18;
   localparam logic [funct_w-1:0] funct_multu = 6'h19;
   localparam logic [funct_w-1:0] funct_div   = 6'h1A;
   localparam logic [funct_w-1:0] funct_divu  = 6'h1B;

   // Opcodes understood by the load/store queue
   localparam logic ls_func_lw = 1'b0;
   localparam logic ls_func_sw = 1'b1;

   typedef logic [word_w-1:0]     word_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;
   typedef logic [tag_w-1:0]      tag_t;

   typedef enum logic [1:0] {
      q_int  = 2'd0,
      q_ls   = 2'd1,
      q_mult = 2'd2,
      q_div  = 2'd3
   } queue_sel_e;

   // One bit per execution queue, indexed by queue_sel_e
   typedef logic [3:0] queue_vec_t;

   typedef struct packed {
      queue_sel_e          queue;
      logic                needs_queue;
      logic                needs_tag;
      logic                is_branch;
      logic                is_jump;
      logic                is_load;
      logic                is_store;
      logic [opcode_w-1:0] int_opcode;
      logic                ls_opcode;
      reg_addr_t           rs;
      reg_addr_t           rt;
      reg_addr_t           dest;
      word_t               imm;
   } decoded_t;

   typedef struct packed {
      logic  valid;
      tag_t  tag;
      word_t data;
      logic  branch;
      logic  branch_taken;
   } cdb_t;

   typedef struct packed {
      word_t imm;
      tag_t  rd_tag;
      tag_t  rs_tag;
      tag_t  rt_tag;
      word_t rs_data;
      word_t rt_data;
      logic  rs_valid;
      logic  rt_valid;
   } equeue_entry_t;

endpackage

// File: hdl/inst_decoder.sv
module inst_decoder (
   input  dispatch_pkg::word_t    inst,
   input  dispatch_pkg::word_t    pc_plus4,
   output dispatch_pkg::decoded_t decoded,
   output dispatch_pkg::word_t    branch_target,
   output dispatch_pkg::word_t    jump_target
);
   import dispatch_pkg::*;

   logic [opcode_w-1:0] opcode;
   logic [funct_w-1:0]  funct;
   logic [imm_w-1:0]    imm16;
   logic [jaddr_w-1:0]  jaddr;
   reg_addr_t           rs;
   reg_addr_t           rt;
   reg_addr_t           rd;
   word_t               imm_sext;

   // Field split for the R, I and J formats
   assign opcode = inst[word_w-1 -: opcode_w];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign funct  = inst[funct_w-1:0];
   assign imm16  = inst[imm_w-1:0];
   assign jaddr  = inst[jaddr_w-1:0];

   assign imm_sext = {{(word_w - imm_w){imm16[imm_w-1]}}, imm16};

   assign branch_target = pc_plus4 + {imm_sext[word_w-3:0], 2'b00};
   // Jumps stay inside the current 256 MB region
   assign jump_target   = {pc_plus4[word_w-1 -: 4], jaddr, 2'b00};

   always_comb begin
      decoded             = '0;
      decoded.queue       = q_int;
      decoded.rs          = rs;
      decoded.rt          = rt;
      decoded.dest        = rd;
      decoded.imm         = imm_sext;
      decoded.ls_opcode   = ls_func_lw;

      case (opcode)
         opcode_rtype: begin
            decoded.needs_queue = 1'b1;
            decoded.needs_tag   = 1'b1;
            if (funct == funct_mult || funct == funct_multu) begin
               decoded.queue = q_mult;
            end else if (funct == funct_div || funct == funct_divu) begin
               decoded.queue = q_div;
            end else begin
               decoded.int_opcode = funct;
            end
         end
         opcode_beq, opcode_bne: begin
            // Branches are resolved by the integer unit and produce no result
            decoded.needs_queue = 1'b1;
            decoded.is_branch   = 1'b1;
            decoded.int_opcode  = opcode;
         end
         opcode_j: begin
            decoded.is_jump = 1'b1;
         end
         opcode_lw: begin
            decoded.queue       = q_ls;
            decoded.needs_queue = 1'b1;
            decoded.needs_tag   = 1'b1;
            decoded.is_load     = 1'b1;
            decoded.ls_opcode   = ls_func_lw;
            decoded.dest        = rt;
         end
         opcode_sw: begin
            decoded.queue       = q_ls;
            decoded.needs_queue = 1'b1;
            decoded.is_store    = 1'b1;
            decoded.ls_opcode   = ls_func_sw;
         end
         default: begin
         end
      endcase
   end

endmodule

// File: hdl/reg_status_table.sv
module reg_status_table (
   input  logic                              clk,
   input  logic                              rst_n,
   input  dispatch_pkg::reg_addr_t           rs,
   input  dispatch_pkg::reg_addr_t           rt,
   input  dispatch_pkg::reg_addr_t           dest,
   input  logic                              set_busy,
   input  dispatch_pkg::tag_t                new_tag,
   input  dispatch_pkg::cdb_t                cdb,
   output dispatch_pkg::tag_t                rs_tag,
   output dispatch_pkg::tag_t                rt_tag,
   output logic                              rs_busy,
   output logic                              rt_busy,
   output logic [dispatch_pkg::num_regs-1:0] write_onehot
);
   import dispatch_pkg::*;

   logic [num_regs-1:0] busy;
   tag_t                prod_tag [num_regs];

   // Every register still waiting on the broadcast tag takes the CDB value
   always_comb begin
      for (int i = 0; i < num_regs; i++) begin
         write_onehot[i] = cdb.valid && busy[i] && (prod_tag[i] == cdb.tag);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
         for (int i = 0; i < num_regs; i++) begin
            prod_tag[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_regs; i++) begin
            // A new producer overrides a completion of the old one
            if (set_busy && dest == reg_addr_t'(i)) begin
               busy[i]     <= 1'b1;
               prod_tag[i] <= new_tag;
            end else if (write_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

   assign rs_tag  = prod_tag[rs];
   assign rt_tag  = prod_tag[rt];
   assign rs_busy = busy[rs];
   assign rt_busy = busy[rt];

endmodule

// File: hdl/reg_file.sv
module reg_file (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [dispatch_pkg::num_regs-1:0] write_onehot,
   input  dispatch_pkg::word_t               write_data,
   input  dispatch_pkg::reg_addr_t           rs,
   input  dispatch_pkg::reg_addr_t           rt,
   output dispatch_pkg::word_t               rs_data,
   output dispatch_pkg::word_t               rt_data
);
   import dispatch_pkg::*;

   word_t regs [num_regs];

   // Several registers may share one producer tag, so all of them are written
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_regs; i++) begin
            if (write_onehot[i]) begin
               regs[i] <= write_data;
            end
         end
      end
   end

   assign rs_data = regs[rs];
   assign rt_data = regs[rt];

endmodule

// File: hdl/tag_pool.sv
module tag_pool (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               pop,
   input  dispatch_pkg::cdb_t cdb,
   output dispatch_pkg::tag_t free_tag,
   output logic               tag_avail
);
   import dispatch_pkg::*;

   tag_t             pool [num_tags];
   tag_t             rd_ptr;
   tag_t             wr_ptr;
   logic [tag_w:0]   count;
   logic             do_pop;
   logic             do_push;

   assign tag_avail = (count != '0);
   assign free_tag  = pool[rd_ptr];
   assign do_pop    = pop && tag_avail;
   assign do_push   = cdb.valid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // Tag 0 is reserved, so the pool starts with 1 to 63 in order
         for (int i = 0; i < num_tags; i++) begin
            pool[i] <= tag_t'((i + 1) % num_tags);
         end
         rd_ptr <= '0;
         wr_ptr <= tag_t'(num_tags - 1);
         count  <= (tag_w + 1)'(num_tags - 1);
      end else begin
         if (do_push) begin
            pool[wr_ptr] <= cdb.tag;
            wr_ptr       <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: hdl/operand_fetch.sv
module operand_fetch (
   input  logic                        clk,
   input  logic                        rst_n,
   input  dispatch_pkg::decoded_t      decoded,
   input  dispatch_pkg::cdb_t          cdb,
   input  dispatch_pkg::tag_t          free_tag,
   input  logic                        dispatch_fire,
   output dispatch_pkg::equeue_entry_t equeue
);
   import dispatch_pkg::*;

   tag_t                rs_tag;
   tag_t                rt_tag;
   logic                rs_busy;
   logic                rt_busy;
   logic [num_regs-1:0] write_onehot;
   word_t               rs_data;
   word_t               rt_data;
   logic                rs_hit;
   logic                rt_hit;

   reg_status_table u_reg_status_table (
      .clk          (clk),
      .rst_n        (rst_n),
      .rs           (decoded.rs),
      .rt           (decoded.rt),
      .dest         (decoded.dest),
      .set_busy     (dispatch_fire && decoded.needs_tag),
      .new_tag      (free_tag),
      .cdb          (cdb),
      .rs_tag       (rs_tag),
      .rt_tag       (rt_tag),
      .rs_busy      (rs_busy),
      .rt_busy      (rt_busy),
      .write_onehot (write_onehot)
   );

   reg_file u_reg_file (
      .clk          (clk),
      .rst_n        (rst_n),
      .write_onehot (write_onehot),
      .write_data   (cdb.data),
      .rs           (decoded.rs),
      .rt           (decoded.rt),
      .rs_data      (rs_data),
      .rt_data      (rt_data)
   );

   // The register file only sees this broadcast at the next edge, so bypass it
   assign rs_hit = rs_busy && cdb.valid && (cdb.tag == rs_tag);
   assign rt_hit = rt_busy && cdb.valid && (cdb.tag == rt_tag);

   assign equeue.imm      = decoded.imm;
   assign equeue.rd_tag   = free_tag;
   assign equeue.rs_tag   = rs_tag;
   // A load writes rt, so its rt tag names the load's own result
   assign equeue.rt_tag   = decoded.is_load ? free_tag : rt_tag;
   assign equeue.rs_data  = rs_hit ? cdb.data : rs_data;
   assign equeue.rt_data  = rt_hit ? cdb.data : rt_data;
   assign equeue.rs_valid = !rs_busy || rs_hit;
   assign equeue.rt_valid = decoded.is_store || !rt_busy || rt_hit;

endmodule

// File: hdl/issue_control.sv
module issue_control (
   input  logic                     clk,
   input  logic                     rst_n,
   input  dispatch_pkg::decoded_t   decoded,
   input  dispatch_pkg::word_t      branch_target,
   input  dispatch_pkg::word_t      jump_target,
   input  logic                     ifq_empty,
   input  dispatch_pkg::queue_vec_t queue_ready,
   input  logic                     tag_avail,
   input  dispatch_pkg::cdb_t       cdb,
   output dispatch_pkg::queue_vec_t queue_en,
   output logic                     ifq_ren,
   output logic                     dispatch_fire,
   output logic                     ifq_redirect,
   output dispatch_pkg::word_t      ifq_redirect_addr
);
   import dispatch_pkg::*;

   typedef enum logic {
      st_dispatch     = 1'b0,
      st_branch_stall = 1'b1
   } state_e;

   state_e state;
   state_e state_next;
   word_t  saved_target;
   logic   tag_ok;
   logic   can_issue;

   assign tag_ok    = !decoded.needs_tag || tag_avail;
   assign can_issue = !ifq_empty && decoded.needs_queue &&
                      queue_ready[decoded.queue] && tag_ok;

   always_comb begin
      dispatch_fire     = 1'b0;
      ifq_redirect      = 1'b0;
      ifq_redirect_addr = '0;
      state_next        = state;

      case (state)
         st_dispatch: begin
            dispatch_fire = can_issue;
            if (!ifq_empty && decoded.is_jump) begin
               ifq_redirect      = 1'b1;
               ifq_redirect_addr = jump_target;
            end
            if (can_issue && decoded.is_branch) begin
               state_next = st_branch_stall;
            end
         end
         st_branch_stall: begin
            if (cdb.branch) begin
               state_next = st_dispatch;
               if (cdb.branch_taken) begin
                  ifq_redirect      = 1'b1;
                  ifq_redirect_addr = saved_target;
               end else begin
                  // A second branch waits one more cycle and goes out from dispatch
                  dispatch_fire = can_issue && !decoded.is_branch;
               end
            end
         end
         default: begin
            state_next = st_dispatch;
         end
      endcase
   end

   assign ifq_ren = dispatch_fire;

   always_comb begin
      queue_en                = '0;
      queue_en[decoded.queue] = dispatch_fire;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_dispatch;
      end else begin
         state <= state_next;
      end
   end

   // Target kept for a taken branch while younger instructions are held
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         saved_target <= '0;
      end else if (dispatch_fire && decoded.is_branch) begin
         saved_target <= branch_target;
      end
   end

endmodule

// File: hdl/dispatch_unit.sv
module dispatch_unit (
   input  logic                              clk,
   input  logic                              rst_n,
   input  dispatch_pkg::word_t               ifq_inst,
   input  dispatch_pkg::word_t               ifq_pc_plus4,
   input  logic                              ifq_empty,
   output logic                              ifq_ren,
   output logic                              ifq_redirect,
   output dispatch_pkg::word_t               ifq_redirect_addr,
   input  dispatch_pkg::cdb_t                cdb,
   input  dispatch_pkg::queue_vec_t          queue_ready,
   output dispatch_pkg::equeue_entry_t       equeue,
   output logic [dispatch_pkg::opcode_w-1:0] int_opcode,
   output logic                              ls_opcode,
   output dispatch_pkg::queue_vec_t          queue_en
);
   import dispatch_pkg::*;

   decoded_t decoded;
   word_t    branch_target;
   word_t    jump_target;
   tag_t     free_tag;
   logic     tag_avail;
   logic     dispatch_fire;

   inst_decoder u_inst_decoder (
      .inst          (ifq_inst),
      .pc_plus4      (ifq_pc_plus4),
      .decoded       (decoded),
      .branch_target (branch_target),
      .jump_target   (jump_target)
   );

   // Only result-producing instructions consume a tag
   tag_pool u_tag_pool (
      .clk       (clk),
      .rst_n     (rst_n),
      .pop       (dispatch_fire && decoded.needs_tag),
      .cdb       (cdb),
      .free_tag  (free_tag),
      .tag_avail (tag_avail)
   );

   operand_fetch u_operand_fetch (
      .clk           (clk),
      .rst_n         (rst_n),
      .decoded       (decoded),
      .cdb           (cdb),
      .free_tag      (free_tag),
      .dispatch_fire (dispatch_fire),
      .equeue        (equeue)
   );

   issue_control u_issue_control (
      .clk               (clk),
      .rst_n             (rst_n),
      .decoded           (decoded),
      .branch_target     (branch_target),
      .jump_target       (jump_target),
      .ifq_empty         (ifq_empty),
      .queue_ready       (queue_ready),
      .tag_avail         (tag_avail),
      .cdb               (cdb),
      .queue_en          (queue_en),
      .ifq_ren           (ifq_ren),
      .dispatch_fire     (dispatch_fire),
      .ifq_redirect      (ifq_redirect),
      .ifq_redirect_addr (ifq_redirect_addr)
   );

   assign int_opcode = decoded.int_opcode;
   assign ls_opcode  = decoded.ls_opcode;

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
   parameter int period       = 100,
   parameter int reset_cycles = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // Reset is released on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: tests/tb_dispatch.sv
module tb_dispatch;
   import dispatch_pkg::*;

   localparam int clk_period = 100;
   localparam int num_rows   = 20;

   localparam logic [funct_w-1:0] funct_add = 6'h20;
   localparam logic [funct_w-1:0] funct_sub = 6'h22;
   localparam logic [funct_w-1:0] funct_and = 6'h24;
   localparam logic [funct_w-1:0] funct_or  = 6'h25;

   // Which optional fields of a row are compared
   localparam logic [3:0] chk_entry  = 4'b0001;
   localparam logic [3:0] chk_rs_tag = 4'b0010;
   localparam logic [3:0] chk_rt_tag = 4'b0100;
   localparam logic [3:0] chk_imm    = 4'b1000;

   typedef struct packed {
      word_t               inst;
      word_t               pc_plus4;
      logic                ifq_empty;
      queue_vec_t          queue_ready;
      cdb_t                cdb;
      logic [3:0]          chk;
      logic                ifq_ren;
      queue_vec_t          queue_en;
      logic [opcode_w-1:0] int_opcode;
      logic                ls_opcode;
      tag_t                rd_tag;
      tag_t                rs_tag;
      tag_t                rt_tag;
      logic                rs_valid;
      word_t               rs_data;
      logic                rt_valid;
      word_t               rt_data;
      word_t               imm;
      logic                ifq_redirect;
      word_t               ifq_redirect_addr;
   } row_t;

   logic                clk;
   logic                rst_n;
   word_t               ifq_inst;
   word_t               ifq_pc_plus4;
   logic                ifq_empty;
   logic                ifq_ren;
   logic                ifq_redirect;
   word_t               ifq_redirect_addr;
   cdb_t                cdb;
   queue_vec_t          queue_ready;
   equeue_entry_t       equeue;
   logic [opcode_w-1:0] int_opcode;
   logic                ls_opcode;
   queue_vec_t          queue_en;

   row_t rows [num_rows];
   int   n_rows;
   int   errors;
   int   checks;

   tb_clock #(.period(clk_period), .reset_cycles(5)) u_tb_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   dispatch_unit u_dispatch_unit (
      .clk               (clk),
      .rst_n             (rst_n),
      .ifq_inst          (ifq_inst),
      .ifq_pc_plus4      (ifq_pc_plus4),
      .ifq_empty         (ifq_empty),
      .ifq_ren           (ifq_ren),
      .ifq_redirect      (ifq_redirect),
      .ifq_redirect_addr (ifq_redirect_addr),
      .cdb               (cdb),
      .queue_ready       (queue_ready),
      .equeue            (equeue),
      .int_opcode        (int_opcode),
      .ls_opcode         (ls_opcode),
      .queue_en          (queue_en)
   );

   function automatic word_t rtype_word(input reg_addr_t rs, input reg_addr_t rt,
                                        input reg_addr_t rd, input logic [5:0] funct);
      return {opcode_rtype, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
                                        input reg_addr_t rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t jtype_word(input logic [25:0] addr);
      return {opcode_j, addr};
   endfunction

   function automatic cdb_t cdb_result(input tag_t tag, input word_t data);
      cdb_t c;
      c       = '0;
      c.valid = 1'b1;
      c.tag   = tag;
      c.data  = data;
      return c;
   endfunction

   function automatic cdb_t cdb_branch(input logic taken);
      cdb_t c;
      c              = '0;
      c.branch       = 1'b1;
      c.branch_taken = taken;
      return c;
   endfunction

   function automatic queue_vec_t one_queue(input queue_sel_e q);
      queue_vec_t v;
      v    = '0;
      v[q] = 1'b1;
      return v;
   endfunction

   // A new row expects no activity until an expect task says otherwise
   task automatic add_row(input word_t inst, input word_t pc_plus4, input logic empty,
                          input queue_vec_t ready, input cdb_t bus);
      row_t r;
      r             = '0;
      r.inst        = inst;
      r.pc_plus4    = pc_plus4;
      r.ifq_empty   = empty;
      r.queue_ready = ready;
      r.cdb         = bus;
      r.rs_valid    = 1'b1;
      r.rt_valid    = 1'b1;
      rows[n_rows]  = r;
      n_rows++;
   endtask

   task automatic expect_dispatch(input queue_sel_e q, input logic [5:0] int_op,
                                  input logic ls_op, input tag_t rd_tag);
      rows[n_rows-1].chk        |= chk_entry;
      rows[n_rows-1].ifq_ren    = 1'b1;
      rows[n_rows-1].queue_en   = one_queue(q);
      rows[n_rows-1].int_opcode = int_op;
      rows[n_rows-1].ls_opcode  = ls_op;
      rows[n_rows-1].rd_tag     = rd_tag;
   endtask

   // A valid operand carries data and a pending one carries its producer tag
   task automatic expect_rs(input logic valid, input word_t value);
      rows[n_rows-1].rs_valid = valid;
      if (valid) begin
         rows[n_rows-1].rs_data = value;
      end else begin
         rows[n_rows-1].rs_tag = tag_t'(value);
         rows[n_rows-1].chk    |= chk_rs_tag;
      end
   endtask

   task automatic expect_rt(input logic valid, input word_t value);
      rows[n_rows-1].rt_valid = valid;
      if (valid) begin
         rows[n_rows-1].rt_data = value;
      end else begin
         rows[n_rows-1].rt_tag = tag_t'(value);
         rows[n_rows-1].chk    |= chk_rt_tag;
      end
   endtask

   task automatic expect_rt_tag(input tag_t tag);
      rows[n_rows-1].rt_tag = tag;
      rows[n_rows-1].chk    |= chk_rt_tag;
   endtask

   task automatic expect_imm(input word_t imm);
      rows[n_rows-1].imm = imm;
      rows[n_rows-1].chk |= chk_imm;
   endtask

   task automatic expect_redirect(input word_t addr);
      rows[n_rows-1].ifq_redirect      = 1'b1;
      rows[n_rows-1].ifq_redirect_addr = addr;
   endtask

   task automatic build_table;
      // ADD r3 = r1 + r2 takes the first tag, then a dependent SUB
      add_row(rtype_word(1, 2, 3, funct_add), 32'h0000_0004, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, funct_add, ls_func_lw, 6'd1);
      add_row(rtype_word(3, 1, 4, funct_sub), 32'h0000_0008, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, funct_sub, ls_func_lw, 6'd2);
      expect_rs(1'b0, 32'd1);
      // Tag 1 completes in the same cycle, so r3 is bypassed from the CDB
      add_row(rtype_word(3, 4, 5, funct_and), 32'h0000_000C, 1'b0, 4'hF,
              cdb_result(6'd1, 32'h1234_5678));
      expect_dispatch(q_int, funct_and, ls_func_lw, 6'd3);
      expect_rs(1'b1, 32'h1234_5678);
      expect_rt(1'b0, 32'd2);
      add_row(rtype_word(3, 0, 6, funct_or), 32'h0000_0010, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, funct_or, ls_func_lw, 6'd4);
      expect_rs(1'b1, 32'h1234_5678);
      // Queue selection for MULT, DIV, LW and SW
      add_row(rtype_word(1, 2, 10, funct_mult), 32'h0000_0014, 1'b0, 4'hF, '0);
      expect_dispatch(q_mult, 6'd0, ls_func_lw, 6'd5);
      add_row(rtype_word(1, 2, 11, funct_div), 32'h0000_0018, 1'b0, 4'hF, '0);
      expect_dispatch(q_div, 6'd0, ls_func_lw, 6'd6);
      add_row(itype_word(opcode_lw, 3, 7, 16'h0008), 32'h0000_001C, 1'b0, 4'hF, '0);
      expect_dispatch(q_ls, 6'd0, ls_func_lw, 6'd7);
      expect_rs(1'b1, 32'h1234_5678);
      expect_rt_tag(6'd7);
      expect_imm(32'h0000_0008);
      add_row(itype_word(opcode_sw, 3, 4, 16'h0004), 32'h0000_0020, 1'b0, 4'hF, '0);
      expect_dispatch(q_ls, 6'd0, ls_func_sw, 6'd8);
      expect_rs(1'b1, 32'h1234_5678);
      expect_imm(32'h0000_0004);
      add_row(rtype_word(1, 2, 8, funct_add), 32'h0000_0024, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, funct_add, ls_func_lw, 6'd8);
      // The integer queue is full for one row and then ready again
      add_row(rtype_word(1, 2, 9, funct_sub), 32'h0000_0028, 1'b0, 4'b1110, '0);
      add_row(rtype_word(1, 2, 9, funct_sub), 32'h0000_0028, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, funct_sub, ls_func_lw, 6'd9);
      // Jump target keeps the upper four bits of pc_plus4
      add_row(jtype_word(26'h000_0100), 32'h4000_0030, 1'b0, 4'hF, '0);
      expect_redirect(32'h4000_0400);
      // Taken BEQ with offset -16 words back from 0x100
      add_row(itype_word(opcode_beq, 1, 2, 16'hFFF0), 32'h0000_0100, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, opcode_beq, ls_func_lw, 6'd10);
      expect_imm(32'hFFFF_FFF0);
      add_row(rtype_word(1, 2, 12, funct_add), 32'h0000_0104, 1'b0, 4'hF, '0);
      add_row(rtype_word(1, 2, 12, funct_add), 32'h0000_0104, 1'b0, 4'hF,
              cdb_branch(1'b1));
      expect_redirect(32'h0000_00C0);
      add_row(rtype_word(1, 2, 12, funct_add), 32'h0000_0104, 1'b1, 4'hF, '0);
      // Not-taken BNE lets the held ADD go in the resolving cycle
      add_row(itype_word(opcode_bne, 1, 2, 16'h0008), 32'h0000_0200, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, opcode_bne, ls_func_lw, 6'd10);
      expect_imm(32'h0000_0008);
      add_row(rtype_word(1, 2, 12, funct_add), 32'h0000_0204, 1'b0, 4'hF,
              cdb_branch(1'b0));
      expect_dispatch(q_int, funct_add, ls_func_lw, 6'd10);
      // Tag 2 completes while the IFQ is empty, then r4 reads from the register file
      add_row(rtype_word(4, 3, 13, funct_add), 32'h0000_0208, 1'b1, 4'hF,
              cdb_result(6'd2, 32'hCAFE_0004));
      add_row(rtype_word(4, 3, 13, funct_add), 32'h0000_0208, 1'b0, 4'hF, '0);
      expect_dispatch(q_int, funct_add, ls_func_lw, 6'd11);
      expect_rs(1'b1, 32'hCAFE_0004);
      expect_rt(1'b1, 32'h1234_5678);
   endtask

   task automatic compare_field(input string name, input word_t actual, input word_t expected);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic drive_row(input row_t r);
      ifq_inst     = r.inst;
      ifq_pc_plus4 = r.pc_plus4;
      ifq_empty    = r.ifq_empty;
      queue_ready  = r.queue_ready;
      cdb          = r.cdb;
   endtask

   task automatic check_row(input row_t r);
      compare_field("ifq_ren", ifq_ren, r.ifq_ren);
      compare_field("queue_en", queue_en, r.queue_en);
      compare_field("ifq_redirect", ifq_redirect, r.ifq_redirect);
      if (r.ifq_redirect) begin
         compare_field("ifq_redirect_addr", ifq_redirect_addr, r.ifq_redirect_addr);
      end
      if ((r.chk & chk_entry) != '0) begin
         if (r.queue_en[q_int]) begin
            compare_field("int_opcode", int_opcode, r.int_opcode);
         end
         if (r.queue_en[q_ls]) begin
            compare_field("ls_opcode", ls_opcode, r.ls_opcode);
         end
         compare_field("equeue.rd_tag", equeue.rd_tag, r.rd_tag);
         compare_field("equeue.rs_valid", equeue.rs_valid, r.rs_valid);
         compare_field("equeue.rt_valid", equeue.rt_valid, r.rt_valid);
         if (r.rs_valid) begin
            compare_field("equeue.rs_data", equeue.rs_data, r.rs_data);
         end
         if (r.rt_valid) begin
            compare_field("equeue.rt_data", equeue.rt_data, r.rt_data);
         end
      end
      if ((r.chk & chk_rs_tag) != '0) begin
         compare_field("equeue.rs_tag", equeue.rs_tag, r.rs_tag);
      end
      if ((r.chk & chk_rt_tag) != '0) begin
         compare_field("equeue.rt_tag", equeue.rt_tag, r.rt_tag);
      end
      if ((r.chk & chk_imm) != '0) begin
         compare_field("equeue.imm", equeue.imm, r.imm);
      end
   endtask

   initial begin
      ifq_inst     = '0;
      ifq_pc_plus4 = '0;
      ifq_empty    = 1'b1;
      queue_ready  = '0;
      cdb          = '0;
      n_rows       = 0;
      errors       = 0;
      checks       = 0;
      build_table();
      wait (rst_n === 1'b1);
      for (int i = 0; i < num_rows; i++) begin
         @(negedge clk);
         drive_row(rows[i]);
         // Outputs are combinational and settle well before the next rising edge
         #(clk_period / 2 - 10);
         check_row(rows[i]);
      end
      @(negedge clk);
      ifq_empty = 1'b1;
      cdb       = '0;
      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      #((num_rows + 10) * clk_period);
      $display("Timeout: the table did not finish within the expected run time");
      $display("tests failed");
      $finish;
   end

endmodule

// File: filelist.f
hdl/dispatch_pkg.sv
hdl/inst_decoder.sv
hdl/reg_status_table.sv
hdl/reg_file.sv
hdl/tag_pool.sv
hdl/operand_fetch.sv
hdl/issue_control.sv
hdl/dispatch_unit.sv
tests/tb_clock.sv
tests/tb_dispatch.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module tb_dispatch -o sim_dispatch

out=$(./obj_dir/sim_dispatch)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
